// File: common/aurora_ctrl_pkg.sv
package aurora_ctrl_pkg;

    // wishbone side
    localparam int WB_ADDR_W = 15;
    localparam int WB_DATA_W = 32;

    // drp side, one port per link
    localparam int DRP_ADDR_W = 10;
    localparam int DRP_DATA_W = 16;

    // per-link inputs
    localparam int STATUS_W = 12;
    localparam int DMON_W   = 16;

    // per-link control fields
    localparam int LOOPBACK_W = 3;
    localparam int TXDIFF_W   = 4;
    localparam int TXCURSOR_W = 5;

    // word index inside one link's control space (byte offset / 4)
    localparam logic [8:0] REG_CONTROL  = 9'd0;
    localparam logic [8:0] REG_STATUS   = 9'd1;
    localparam logic [8:0] REG_EYESCAN  = 9'd2;
    localparam logic [8:0] REG_DMONITOR = 9'd3;

    // tx swing out of reset
    localparam logic [TXDIFF_W-1:0] TXDIFF_DEFAULT = 4'b1100;

    // 0x4000 and up: 0x1000 of drp space per lane
    typedef struct packed {
        logic                  drp_sel;
        logic [1:0]            lane;
        logic [DRP_ADDR_W-1:0] addr;
        logic [1:0]            unused;
    } drp_addr_t;

    // below 0x4000: lanes at 0x800 apart, globals from 0x2000
    typedef struct packed {
        logic       drp_sel;
        logic       global_sel;
        logic [1:0] lane;
        logic [8:0] word;
        logic [1:0] unused;
    } ctrl_addr_t;

    typedef union packed {
        drp_addr_t  drp;
        ctrl_addr_t ctrl;
    } wb_addr_u;

endpackage

// File: drp/drp_bridge.sv
`timescale 1ns/1ps

module drp_bridge #(
    parameter int NUM_MGT = 4
) (
    input  logic                                           drp_start_i,
    input  logic [aurora_ctrl_pkg::WB_ADDR_W-1:0]          wb_adr_i,
    input  logic [aurora_ctrl_pkg::WB_DATA_W-1:0]          wb_dat_i,
    input  logic                                           wb_we_i,
    input  logic [NUM_MGT*aurora_ctrl_pkg::DRP_DATA_W-1:0] drp_do_i,
    input  logic [NUM_MGT-1:0]                             drp_rdy_i,
    output logic [NUM_MGT-1:0]                             drp_en_o,
    output logic [aurora_ctrl_pkg::DRP_ADDR_W-1:0]         drp_addr_o,
    output logic [aurora_ctrl_pkg::DRP_DATA_W-1:0]         drp_di_o,
    output logic                                           drp_we_o,
    output logic                                           drp_ready_o,
    output logic [aurora_ctrl_pkg::DRP_DATA_W-1:0]         drp_rdata_o
);

    localparam int DD_W = aurora_ctrl_pkg::DRP_DATA_W;

    aurora_ctrl_pkg::wb_addr_u adr;

    assign adr = wb_adr_i;

    // address, data and write enable are common to all ports
    assign drp_addr_o = adr.drp.addr;
    assign drp_di_o   = wb_dat_i[DD_W-1:0];
    assign drp_we_o   = wb_we_i;

    always_comb begin
        drp_en_o    = '0;
        // a lane that is not built answers at once with zero
        drp_ready_o = 1'b1;
        drp_rdata_o = '0;
        for (int i = 0; i < NUM_MGT; i++) begin
            if (int'(adr.drp.lane) == i) begin
                drp_en_o[i] = drp_start_i;
                drp_ready_o = drp_rdy_i[i];
                drp_rdata_o = drp_do_i[i*DD_W +: DD_W];
            end
        end
    end

endmodule

// File: filelist.f
common/aurora_ctrl_pkg.sv
drp/drp_bridge.sv
link_regs/link_ctrl_regs.sv
hdl/wb_access_fsm.sv
hdl/aurora_ctrl_top.sv
sim/drp_lane_model.sv
sim/tb_aurora_ctrl.sv

// File: hdl/aurora_ctrl_top.sv
`timescale 1ns/1ps

module aurora_ctrl_top #(
    parameter int NUM_MGT = 4
) (
    input  logic                                           wb_clk_i,
    input  logic                                           wb_rst_i,
    input  logic                                           wb_cyc_i,
    input  logic                                           wb_stb_i,
    input  logic                                           wb_we_i,
    input  logic [aurora_ctrl_pkg::WB_ADDR_W-1:0]          wb_adr_i,
    input  logic [aurora_ctrl_pkg::WB_DATA_W-1:0]          wb_dat_i,
    input  logic [aurora_ctrl_pkg::WB_DATA_W/8-1:0]        wb_sel_i,
    output logic                                           wb_ack_o,
    output logic [aurora_ctrl_pkg::WB_DATA_W-1:0]          wb_dat_o,
    input  logic [NUM_MGT*aurora_ctrl_pkg::STATUS_W-1:0]   link_status_i,
    input  logic [NUM_MGT*aurora_ctrl_pkg::DMON_W-1:0]     dmonitor_i,
    output logic [NUM_MGT-1:0]                             drp_en_o,
    output logic [aurora_ctrl_pkg::DRP_ADDR_W-1:0]         drp_addr_o,
    output logic [aurora_ctrl_pkg::DRP_DATA_W-1:0]         drp_di_o,
    output logic                                           drp_we_o,
    input  logic [NUM_MGT*aurora_ctrl_pkg::DRP_DATA_W-1:0] drp_do_i,
    input  logic [NUM_MGT-1:0]                             drp_rdy_i,
    output logic                                           reset_o,
    output logic                                           gt_reset_o,
    output logic                                           global_datapath_reset_o,
    output logic                                           global_linkerr_reset_o,
    output logic [NUM_MGT-1:0]                             eyescan_reset_o,
    output logic [NUM_MGT-1:0]                             powerdown_o,
    output logic [NUM_MGT*aurora_ctrl_pkg::LOOPBACK_W-1:0] loopback_o,
    output logic [NUM_MGT-1:0]                             datapath_reset_o,
    output logic [NUM_MGT-1:0]                             linkerr_reset_o,
    output logic [NUM_MGT*aurora_ctrl_pkg::TXDIFF_W-1:0]   txdiffctrl_o,
    output logic [NUM_MGT*aurora_ctrl_pkg::TXCURSOR_W-1:0] txprecursor_o,
    output logic [NUM_MGT*aurora_ctrl_pkg::TXCURSOR_W-1:0] txpostcursor_o
);

    // sequencer <-> register bank
    logic [aurora_ctrl_pkg::WB_DATA_W-1:0]  ctrl_rdata;
    logic                                   wr_commit;
    // sequencer <-> drp bridge
    logic                                   drp_start;
    logic                                   drp_ready;
    logic [aurora_ctrl_pkg::DRP_DATA_W-1:0] drp_rdata;

    wb_access_fsm u_fsm (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .ctrl_rdata_i (ctrl_rdata),
        .drp_ready_i  (drp_ready),
        .drp_rdata_i  (drp_rdata),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o),
        .drp_start_o  (drp_start),
        .wr_commit_o  (wr_commit)
    );

    link_ctrl_regs #(.NUM_MGT(NUM_MGT)) u_regs (
        .wb_clk_i                (wb_clk_i),
        .wb_rst_i                (wb_rst_i),
        .wr_commit_i             (wr_commit),
        .wb_adr_i                (wb_adr_i),
        .wb_dat_i                (wb_dat_i),
        .wb_sel_i                (wb_sel_i),
        .link_status_i           (link_status_i),
        .dmonitor_i              (dmonitor_i),
        .ctrl_rdata_o            (ctrl_rdata),
        .reset_o                 (reset_o),
        .gt_reset_o              (gt_reset_o),
        .global_datapath_reset_o (global_datapath_reset_o),
        .global_linkerr_reset_o  (global_linkerr_reset_o),
        .eyescan_reset_o         (eyescan_reset_o),
        .powerdown_o             (powerdown_o),
        .loopback_o              (loopback_o),
        .datapath_reset_o        (datapath_reset_o),
        .linkerr_reset_o         (linkerr_reset_o),
        .txdiffctrl_o            (txdiffctrl_o),
        .txprecursor_o           (txprecursor_o),
        .txpostcursor_o          (txpostcursor_o)
    );

    drp_bridge #(.NUM_MGT(NUM_MGT)) u_drp (
        .drp_start_i (drp_start),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_we_i     (wb_we_i),
        .drp_do_i    (drp_do_i),
        .drp_rdy_i   (drp_rdy_i),
        .drp_en_o    (drp_en_o),
        .drp_addr_o  (drp_addr_o),
        .drp_di_o    (drp_di_o),
        .drp_we_o    (drp_we_o),
        .drp_ready_o (drp_ready),
        .drp_rdata_o (drp_rdata)
    );

endmodule

// File: hdl/wb_access_fsm.sv
`timescale 1ns/1ps

module wb_access_fsm (
    input  logic                                   wb_clk_i,
    input  logic                                   wb_rst_i,
    input  logic                                   wb_cyc_i,
    input  logic                                   wb_stb_i,
    input  logic                                   wb_we_i,
    input  logic [aurora_ctrl_pkg::WB_ADDR_W-1:0]  wb_adr_i,
    input  logic [aurora_ctrl_pkg::WB_DATA_W-1:0]  ctrl_rdata_i,
    input  logic                                   drp_ready_i,
    input  logic [aurora_ctrl_pkg::DRP_DATA_W-1:0] drp_rdata_i,
    output logic                                   wb_ack_o,
    output logic [aurora_ctrl_pkg::WB_DATA_W-1:0]  wb_dat_o,
    output logic                                   drp_start_o,
    output logic                                   wr_commit_o
);

    localparam int PAD_W = aurora_ctrl_pkg::WB_DATA_W - aurora_ctrl_pkg::DRP_DATA_W;

    localparam logic [1:0] IDLE     = 2'd0;
    localparam logic [1:0] ACK      = 2'd1;
    localparam logic [1:0] DRP_WAIT = 2'd2;

    logic [1:0]                state;
    logic                      req;
    aurora_ctrl_pkg::wb_addr_u adr;

    assign adr = wb_adr_i;
    // master holds the request until it sees ack
    assign req = wb_cyc_i && wb_stb_i;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= adr.drp.drp_sel ? DRP_WAIT : ACK;
                    end
                end
                DRP_WAIT: begin
                    // hold here until the addressed lane answers
                    if (drp_ready_i) begin
                        state <= ACK;
                    end
                end
                // ack lasts one cycle, the unused code falls back too
                default: state <= IDLE;
            endcase
        end
    end

    // read data is captured once and held through the ack cycle
    always_ff @(posedge wb_clk_i) begin
        if (req && !wb_we_i) begin
            if (state == IDLE && !adr.drp.drp_sel) begin
                wb_dat_o <= ctrl_rdata_i;
            end else if (state == DRP_WAIT && drp_ready_i) begin
                wb_dat_o <= {{PAD_W{1'b0}}, drp_rdata_i};
            end
        end
    end

    assign wb_ack_o = (state == ACK);

    // single-cycle enable toward the drp port
    assign drp_start_o = (state == IDLE) && req && adr.drp.drp_sel;

    // register bank updates at the edge closing the ack
    assign wr_commit_o = (state == ACK) && req && wb_we_i;

endmodule

// File: link_regs/link_ctrl_regs.sv
`timescale 1ns/1ps

module link_ctrl_regs #(
    parameter int NUM_MGT = 4
) (
    input  logic                                           wb_clk_i,
    input  logic                                           wb_rst_i,
    input  logic                                           wr_commit_i,
    input  logic [aurora_ctrl_pkg::WB_ADDR_W-1:0]          wb_adr_i,
    input  logic [aurora_ctrl_pkg::WB_DATA_W-1:0]          wb_dat_i,
    input  logic [aurora_ctrl_pkg::WB_DATA_W/8-1:0]        wb_sel_i,
    input  logic [NUM_MGT*aurora_ctrl_pkg::STATUS_W-1:0]   link_status_i,
    input  logic [NUM_MGT*aurora_ctrl_pkg::DMON_W-1:0]     dmonitor_i,
    output logic [aurora_ctrl_pkg::WB_DATA_W-1:0]          ctrl_rdata_o,
    output logic                                           reset_o,
    output logic                                           gt_reset_o,
    output logic                                           global_datapath_reset_o,
    output logic                                           global_linkerr_reset_o,
    output logic [NUM_MGT-1:0]                             eyescan_reset_o,
    output logic [NUM_MGT-1:0]                             powerdown_o,
    output logic [NUM_MGT*aurora_ctrl_pkg::LOOPBACK_W-1:0] loopback_o,
    output logic [NUM_MGT-1:0]                             datapath_reset_o,
    output logic [NUM_MGT-1:0]                             linkerr_reset_o,
    output logic [NUM_MGT*aurora_ctrl_pkg::TXDIFF_W-1:0]   txdiffctrl_o,
    output logic [NUM_MGT*aurora_ctrl_pkg::TXCURSOR_W-1:0] txprecursor_o,
    output logic [NUM_MGT*aurora_ctrl_pkg::TXCURSOR_W-1:0] txpostcursor_o
);

    localparam int DW    = aurora_ctrl_pkg::WB_DATA_W;
    localparam int ST_W  = aurora_ctrl_pkg::STATUS_W;
    localparam int DM_W  = aurora_ctrl_pkg::DMON_W;
    localparam int LB_W  = aurora_ctrl_pkg::LOOPBACK_W;
    localparam int TD_W  = aurora_ctrl_pkg::TXDIFF_W;
    localparam int TC_W  = aurora_ctrl_pkg::TXCURSOR_W;

    aurora_ctrl_pkg::wb_addr_u adr;
    logic                      wr_ctrl;
    logic                      wr_global;
    logic [DW-1:0]             control_word [NUM_MGT];
    logic [DW-1:0]             eyescan_word [NUM_MGT];

    assign adr = wb_adr_i;
    // an ack that closes a drp access must not land here
    assign wr_ctrl = wr_commit_i && !adr.ctrl.drp_sel;
    // lane bits are ignored in the global space
    assign wr_global = wr_ctrl && adr.ctrl.global_sel
                       && adr.ctrl.word == aurora_ctrl_pkg::REG_CONTROL;

    // global word, reset and gt_reset are shared by every link
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            reset_o                 <= 1'b0;
            gt_reset_o              <= 1'b0;
            global_datapath_reset_o <= 1'b0;
            global_linkerr_reset_o  <= 1'b0;
        end else if (wr_global) begin
            if (wb_sel_i[0]) begin
                reset_o    <= wb_dat_i[0];
                gt_reset_o <= wb_dat_i[1];
            end
            if (wb_sel_i[3]) begin
                global_datapath_reset_o <= wb_dat_i[30];
                global_linkerr_reset_o  <= wb_dat_i[31];
            end
        end
    end

    for (genvar i = 0; i < NUM_MGT; i++) begin : g_lane
        logic            wr_lane;
        logic            eyescan_reset_r;
        logic            powerdown_r;
        logic [LB_W-1:0] loopback_r;
        logic            datapath_reset_r;
        logic            linkerr_reset_r;
        logic [TD_W-1:0] txdiff_r;
        logic [TC_W-1:0] precursor_r;
        logic [TC_W-1:0] postcursor_r;

        assign wr_lane = wr_ctrl && !adr.ctrl.global_sel && (int'(adr.ctrl.lane) == i);

        always_ff @(posedge wb_clk_i) begin
            if (wb_rst_i) begin
                eyescan_reset_r  <= 1'b0;
                powerdown_r      <= 1'b0;
                loopback_r       <= '0;
                datapath_reset_r <= 1'b0;
                linkerr_reset_r  <= 1'b0;
                txdiff_r         <= aurora_ctrl_pkg::TXDIFF_DEFAULT;
                precursor_r      <= '0;
                postcursor_r     <= '0;
            end else if (wr_lane) begin
                if (adr.ctrl.word == aurora_ctrl_pkg::REG_CONTROL) begin
                    if (wb_sel_i[0]) begin
                        eyescan_reset_r <= wb_dat_i[2];
                        powerdown_r     <= wb_dat_i[3];
                        loopback_r      <= wb_dat_i[4 +: LB_W];
                    end
                    if (wb_sel_i[3]) begin
                        datapath_reset_r <= wb_dat_i[30];
                        linkerr_reset_r  <= wb_dat_i[31];
                    end
                end
                // each cursor/swing field owns its own byte lane
                if (adr.ctrl.word == aurora_ctrl_pkg::REG_EYESCAN) begin
                    if (wb_sel_i[0]) txdiff_r <= wb_dat_i[0 +: TD_W];
                    if (wb_sel_i[1]) precursor_r <= wb_dat_i[8 +: TC_W];
                    if (wb_sel_i[2]) postcursor_r <= wb_dat_i[16 +: TC_W];
                end
            end
        end

        // bits 1:0 mirror the global reset pair
        assign control_word[i] = {linkerr_reset_r, datapath_reset_r, 23'b0, loopback_r,
                                  powerdown_r, eyescan_reset_r, gt_reset_o, reset_o};
        assign eyescan_word[i] = {11'b0, postcursor_r, 3'b0, precursor_r, 4'b0, txdiff_r};

        assign eyescan_reset_o[i]              = eyescan_reset_r;
        assign powerdown_o[i]                  = powerdown_r;
        assign loopback_o[i*LB_W +: LB_W]      = loopback_r;
        assign datapath_reset_o[i]             = datapath_reset_r;
        assign linkerr_reset_o[i]              = linkerr_reset_r;
        assign txdiffctrl_o[i*TD_W +: TD_W]    = txdiff_r;
        assign txprecursor_o[i*TC_W +: TC_W]   = precursor_r;
        assign txpostcursor_o[i*TC_W +: TC_W]  = postcursor_r;
    end

    // readback, absent lanes and undecoded words give zero
    always_comb begin
        ctrl_rdata_o = '0;
        if (adr.ctrl.global_sel) begin
            if (adr.ctrl.word == aurora_ctrl_pkg::REG_CONTROL) begin
                ctrl_rdata_o = {global_linkerr_reset_o, global_datapath_reset_o, 28'b0,
                                gt_reset_o, reset_o};
            end
        end else begin
            for (int i = 0; i < NUM_MGT; i++) begin
                if (int'(adr.ctrl.lane) == i) begin
                    case (adr.ctrl.word)
                        aurora_ctrl_pkg::REG_CONTROL:  ctrl_rdata_o = control_word[i];
                        aurora_ctrl_pkg::REG_STATUS:
                            ctrl_rdata_o = {{(DW-ST_W){1'b0}}, link_status_i[i*ST_W +: ST_W]};
                        aurora_ctrl_pkg::REG_EYESCAN:  ctrl_rdata_o = eyescan_word[i];
                        aurora_ctrl_pkg::REG_DMONITOR:
                            ctrl_rdata_o = {{(DW-DM_W){1'b0}}, dmonitor_i[i*DM_W +: DM_W]};
                        default: ctrl_rdata_o = '0;
                    endcase
                end
            end
        end
    end

endmodule

// File: sim/drp_lane_model.sv
`timescale 1ns/1ps

module drp_lane_model (
    input  logic                                   wb_clk_i,
    input  logic                                   wb_rst_i,
    input  logic                                   en_i,
    input  logic                                   we_i,
    input  logic [aurora_ctrl_pkg::DRP_ADDR_W-1:0] addr_i,
    input  logic [aurora_ctrl_pkg::DRP_DATA_W-1:0] di_i,
    input  logic [3:0]                             lat_i,
    output logic                                   rdy_o,
    output logic [aurora_ctrl_pkg::DRP_DATA_W-1:0] do_o
);

    logic [aurora_ctrl_pkg::DRP_DATA_W-1:0] mem [2**aurora_ctrl_pkg::DRP_ADDR_W];
    logic [3:0]                             wait_cnt;
    logic                                   busy;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            busy     <= 1'b0;
            wait_cnt <= '0;
            rdy_o    <= 1'b0;
            do_o     <= '0;
        end else begin
            // ready is a single-cycle pulse
            rdy_o <= 1'b0;
            if (en_i) begin
                // latency is latched with the enable
                busy     <= 1'b1;
                wait_cnt <= lat_i;
                if (we_i) begin
                    mem[addr_i] <= di_i;
                end else begin
                    do_o <= mem[addr_i];
                end
            end else if (busy) begin
                if (wait_cnt <= 4'd1) begin
                    busy  <= 1'b0;
                    rdy_o <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 4'd1;
                end
            end
        end
    end

endmodule

// File: sim/tb_aurora_ctrl.sv
`timescale 1ns/1ps

module tb_aurora_ctrl;

    localparam int NUM_MGT = 4;
    // about 200 accesses of up to 20 cycles plus margin
    localparam int TIMEOUT = 5000;
    localparam int ST_W = aurora_ctrl_pkg::STATUS_W;
    localparam int DM_W = aurora_ctrl_pkg::DMON_W;
    localparam int DD_W = aurora_ctrl_pkg::DRP_DATA_W;

    logic                    wb_clk_i;
    logic                    wb_rst_i;
    logic                    wb_cyc_i;
    logic                    wb_stb_i;
    logic                    wb_we_i;
    logic [14:0]             wb_adr_i;
    logic [31:0]             wb_dat_i;
    logic [3:0]              wb_sel_i;
    logic                    wb_ack_o;
    logic [31:0]             wb_dat_o;
    logic [NUM_MGT*ST_W-1:0] link_status_i;
    logic [NUM_MGT*DM_W-1:0] dmonitor_i;
    logic [NUM_MGT-1:0]      drp_en_o;
    logic [9:0]              drp_addr_o;
    logic [15:0]             drp_di_o;
    logic                    drp_we_o;
    wire  [NUM_MGT*DD_W-1:0] drp_do_i;
    wire  [NUM_MGT-1:0]      drp_rdy_i;
    logic                    reset_o;
    logic                    gt_reset_o;
    logic                    global_datapath_reset_o;
    logic                    global_linkerr_reset_o;
    logic [NUM_MGT-1:0]      eyescan_reset_o;
    logic [NUM_MGT-1:0]      powerdown_o;
    logic [NUM_MGT*3-1:0]    loopback_o;
    logic [NUM_MGT-1:0]      datapath_reset_o;
    logic [NUM_MGT-1:0]      linkerr_reset_o;
    logic [NUM_MGT*4-1:0]    txdiffctrl_o;
    logic [NUM_MGT*5-1:0]    txprecursor_o;
    logic [NUM_MGT*5-1:0]    txpostcursor_o;

    // shadow of the written fields and the applied inputs
    logic        sh_reset;
    logic        sh_gt_reset;
    logic        sh_gdp;
    logic        sh_gle;
    logic [31:0] sh_ctrl [NUM_MGT];
    logic [31:0] sh_eye [NUM_MGT];
    logic [11:0] sh_status [NUM_MGT];
    logic [15:0] sh_dmon [NUM_MGT];
    logic [15:0] sh_drp [NUM_MGT*1024];

    logic [3:0]  drp_lat [NUM_MGT];
    int          en_seen [NUM_MGT];
    logic        rdy_seen [NUM_MGT];
    logic [31:0] rng;
    int          cycles;
    int          check_cnt;
    int          err_cnt;
    int          test_num;
    int          chk_start;
    int          err_start;
    string       name_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] got_q [$];

    aurora_ctrl_top #(.NUM_MGT(NUM_MGT)) aurora_ctrl_top_i (.*);

    for (genvar g = 0; g < NUM_MGT; g++) begin : g_model
        drp_lane_model lane_model_i (
            .wb_clk_i (wb_clk_i),
            .wb_rst_i (wb_rst_i),
            .en_i     (drp_en_o[g]),
            .we_i     (drp_we_o),
            .addr_i   (drp_addr_o),
            .di_i     (drp_di_o),
            .lat_i    (drp_lat[g]),
            .rdy_o    (drp_rdy_i[g]),
            .do_o     (drp_do_i[g*DD_W +: DD_W])
        );
    end

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge wb_clk_i);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Checks failed");
        $finish;
    end

    // count enable pulses and note a ready that comes before the ack
    always @(posedge wb_clk_i) begin
        for (int l = 0; l < NUM_MGT; l++) begin
            if (drp_en_o[l]) en_seen[l] = en_seen[l] + 1;
            if (drp_rdy_i[l] && !wb_ack_o) rdy_seen[l] = 1'b1;
        end
    end

    // compare process draining what the stimulus queued
    always @(posedge wb_clk_i) begin
        while (got_q.size() > 0) begin
            check_eq(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
        end
    end

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic push_check(input string name, input logic [31:0] exp, input logic [31:0] got);
        name_q.push_back(name);
        exp_q.push_back(exp);
        got_q.push_back(got);
    endtask

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [14:0] ctrl_addr(input int lane, input int word);
        return {2'b00, lane[1:0], word[8:0], 2'b00};
    endfunction

    // shadow update following the write rules of the register map
    function automatic void apply_write(input logic [14:0] a, input logic [31:0] d,
                                        input logic [3:0] sel);
        logic [31:0] m;
        int          lane;
        m = '0;
        lane = int'(a[12:11]);
        if (a[14]) begin
            sh_drp[{a[13:12], a[11:2]}] = d[15:0];
        end else if (a[13]) begin
            if (a[10:2] == 9'd0 && sel[0]) begin
                sh_reset    = d[0];
                sh_gt_reset = d[1];
            end
            if (a[10:2] == 9'd0 && sel[3]) begin
                sh_gdp = d[30];
                sh_gle = d[31];
            end
        end else if (lane < NUM_MGT && a[10:2] == 9'd0) begin
            if (sel[0]) m = m | 32'h0000_007C;
            if (sel[3]) m = m | 32'hC000_0000;
            sh_ctrl[lane] = (sh_ctrl[lane] & ~m) | (d & m);
        end else if (lane < NUM_MGT && a[10:2] == 9'd2) begin
            if (sel[0]) m = m | 32'h0000_000F;
            if (sel[1]) m = m | 32'h0000_1F00;
            if (sel[2]) m = m | 32'h001F_0000;
            sh_eye[lane] = (sh_eye[lane] & ~m) | (d & m);
        end
    endfunction

    // reference model of the read word
    function automatic logic [31:0] exp_read(input logic [14:0] a);
        int lane;
        lane = int'(a[12:11]);
        if (a[14]) return {16'h0, sh_drp[{a[13:12], a[11:2]}]};
        if (a[13]) return (a[10:2] == 9'd0) ? {sh_gle, sh_gdp, 28'h0, sh_gt_reset, sh_reset} : 0;
        if (lane >= NUM_MGT) return 32'h0;
        case (a[10:2])
            9'd0: return sh_ctrl[lane] | {30'h0, sh_gt_reset, sh_reset};
            9'd1: return {20'h0, sh_status[lane]};
            9'd2: return sh_eye[lane];
            9'd3: return {16'h0, sh_dmon[lane]};
            default: return 32'h0;
        endcase
    endfunction

    // starts on a falling edge and returns on one with the bus idle
    task automatic bus_access(input logic [14:0] a, input logic we, input logic [31:0] d,
                              input logic [3:0] sel, output logic [31:0] rdata);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = a;
        wb_dat_i = d;
        wb_sel_i = sel;
        do @(negedge wb_clk_i); while (!wb_ack_o);
        rdata = wb_dat_o;
        // request stays up through the edge closing the ack
        @(negedge wb_clk_i);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic reg_write(input logic [14:0] a, input logic [31:0] d, input logic [3:0] sel);
        logic [31:0] rdata;
        apply_write(a, d, sel);
        bus_access(a, 1'b1, d, sel, rdata);
    endtask

    task automatic reg_read_check(input logic [14:0] a);
        logic [31:0] rdata;
        bus_access(a, 1'b0, 32'h0, 4'hF, rdata);
        push_check($sformatf("wb_dat_o @%h", a), exp_read(a), rdata);
    endtask

    task automatic drp_access(input int lane, input logic [9:0] daddr, input logic we,
                              input logic [31:0] d);
        logic [14:0] a;
        logic [31:0] rdata;
        a = {1'b1, lane[1:0], daddr, 2'b00};
        drp_lat[lane] = 4'(next_rand() % 8 + 1);
        for (int l = 0; l < NUM_MGT; l++) begin
            en_seen[l]  = 0;
            rdy_seen[l] = 1'b0;
        end
        if (we) apply_write(a, d, 4'hF);
        bus_access(a, we, d, 4'hF, rdata);
        for (int l = 0; l < NUM_MGT; l++) begin
            push_check($sformatf("drp_en_o[%0d] pulses", l), (l == lane), en_seen[l]);
        end
        push_check($sformatf("drp_rdy_i[%0d] before ack", lane), 1, rdy_seen[lane]);
        if (!we) push_check($sformatf("wb_dat_o @%h", a), exp_read(a), rdata);
    endtask

    task automatic check_outputs();
        logic [NUM_MGT-1:0]   esr;
        logic [NUM_MGT-1:0]   pd;
        logic [NUM_MGT-1:0]   dp;
        logic [NUM_MGT-1:0]   le;
        logic [NUM_MGT*3-1:0] lb;
        logic [NUM_MGT*4-1:0] td;
        logic [NUM_MGT*5-1:0] pre;
        logic [NUM_MGT*5-1:0] post;
        for (int i = 0; i < NUM_MGT; i++) begin
            esr[i]         = sh_ctrl[i][2];
            pd[i]          = sh_ctrl[i][3];
            lb[i*3 +: 3]   = sh_ctrl[i][6:4];
            dp[i]          = sh_ctrl[i][30];
            le[i]          = sh_ctrl[i][31];
            td[i*4 +: 4]   = sh_eye[i][3:0];
            pre[i*5 +: 5]  = sh_eye[i][12:8];
            post[i*5 +: 5] = sh_eye[i][20:16];
        end
        push_check("reset_o", sh_reset, reset_o);
        push_check("gt_reset_o", sh_gt_reset, gt_reset_o);
        push_check("global_datapath_reset_o", sh_gdp, global_datapath_reset_o);
        push_check("global_linkerr_reset_o", sh_gle, global_linkerr_reset_o);
        push_check("eyescan_reset_o", esr, eyescan_reset_o);
        push_check("powerdown_o", pd, powerdown_o);
        push_check("loopback_o", lb, loopback_o);
        push_check("datapath_reset_o", dp, datapath_reset_o);
        push_check("linkerr_reset_o", le, linkerr_reset_o);
        push_check("txdiffctrl_o", td, txdiffctrl_o);
        push_check("txprecursor_o", pre, txprecursor_o);
        push_check("txpostcursor_o", post, txpostcursor_o);
    endtask

    // global word write, then every view of the four global bits
    task automatic global_write_check(input logic [31:0] d, input logic [3:0] sel);
        reg_write(15'h2000, d, sel);
        check_outputs();
        for (int i = 0; i < NUM_MGT; i++) begin
            reg_read_check(ctrl_addr(i, 0));
        end
        reg_read_check(15'h2000);
    endtask

    // one edge lets the compare process drain the queue first
    task automatic test_done(input string name);
        @(negedge wb_clk_i);
        test_num++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, name,
                 check_cnt - chk_start, err_cnt - err_start);
        chk_start = check_cnt;
        err_start = err_cnt;
    endtask

    initial begin
        logic [31:0] r;
        int          lane;
        int          dl [16];
        logic [9:0]  da [16];

        wb_rst_i      = 1'b1;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wb_we_i       = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        wb_sel_i      = '0;
        link_status_i = '0;
        dmonitor_i    = '0;
        rng           = 32'h8a27_21f4;
        check_cnt     = 0;
        err_cnt       = 0;
        test_num      = 0;
        chk_start     = 0;
        err_start     = 0;
        sh_reset      = 1'b0;
        sh_gt_reset   = 1'b0;
        sh_gdp        = 1'b0;
        sh_gle        = 1'b0;
        for (int i = 0; i < NUM_MGT; i++) begin
            sh_ctrl[i]   = 32'h0;
            sh_eye[i]    = 32'h0000_000C;
            sh_status[i] = '0;
            sh_dmon[i]   = '0;
            drp_lat[i]   = 4'd1;
            en_seen[i]   = 0;
            rdy_seen[i]  = 1'b0;
        end
        repeat (3) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        wb_rst_i = 1'b0;

        for (int i = 0; i < NUM_MGT; i++) begin
            reg_read_check(ctrl_addr(i, 0));
            reg_read_check(ctrl_addr(i, 2));
        end
        check_outputs();
        test_done("reset defaults");

        // random data and byte selects on control and eye-scan words
        for (int k = 0; k < 40; k++) begin
            r = next_rand();
            lane = int'(r[7:0]) % NUM_MGT;
            reg_write(ctrl_addr(lane, r[8] ? 2 : 0), next_rand(), r[15:12]);
            reg_read_check(ctrl_addr(lane, r[8] ? 2 : 0));
            check_outputs();
        end
        for (int i = 0; i < NUM_MGT; i++) begin
            reg_read_check(ctrl_addr(i, 0));
            reg_read_check(ctrl_addr(i, 2));
        end
        test_done("lane register writes");

        // patterns that tell the four global bits apart and exercise the byte selects
        global_write_check(32'h4000_0001, 4'hF);
        global_write_check(32'h8000_0002, 4'hF);
        global_write_check(32'h4000_0002, 4'hF);
        global_write_check(32'h0000_0003, 4'h1);
        global_write_check(32'hC000_0000, 4'h8);
        test_done("global resets");

        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < NUM_MGT; i++) begin
                r = next_rand();
                sh_status[i] = r[11:0];
                sh_dmon[i]   = r[31:16];
                link_status_i[i*ST_W +: ST_W] = r[11:0];
                dmonitor_i[i*DM_W +: DM_W]    = r[31:16];
            end
            for (int i = 0; i < NUM_MGT; i++) begin
                reg_read_check(ctrl_addr(i, 1));
                reg_read_check(ctrl_addr(i, 3));
            end
        end
        test_done("status and monitor readback");

        for (int k = 0; k < 16; k++) begin
            r = next_rand();
            dl[k] = int'(r[7:0]) % NUM_MGT;
            da[k] = r[17:8];
            drp_access(dl[k], da[k], 1'b1, next_rand());
        end
        for (int k = 0; k < 16; k++) drp_access(dl[k], da[k], 1'b0, 32'h0);
        test_done("drp write and read");

        $display("tests: %0d, checks: %0d, errors: %0d", test_num, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
